//--- rtl/csr_access_ctrl.sv
`timescale 1ns/1ps

module csr_access_ctrl import csr_types_pkg::*, csr_map_pkg::*; #(
	parameter int XLEN = 64
) (
	input  logic      CLK,
	input  logic      rst_n,
	input  logic      req,
	input  csr_addr_t addr,
	input  xlen_t     wdata,
	input  logic      rw,
	input  logic      rs,
	input  logic      rc,
	input  logic      trap,
	input  logic      xret,
	input  xlen_t     mstatus_trap,
	input  xlen_t     mepc_trap,
	input  xlen_t     mcause_trap,
	input  xlen_t     mtval_trap,
	output slot_idx_t hit_slot,
	output logic      hit_valid,
	output logic      ro_hit,
	output logic      illegal,
	csr_slot_if.ctrl  slots
);

	localparam xlen_t XMASK = xlen_t'({XLEN{1'b1}});

	csr_kind_t kind;
	xlen_t operand;
	xlen_t old_val;
	xlen_t merged;
	logic is_write;

	assign kind = {rc, rs, rw};
	assign operand = wdata & XMASK;

	// slot table lookup
	always_comb begin
		hit_valid = 1'b0;
		hit_slot = '0;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			if (addr == SLOT_ADDR[i]) begin
				hit_valid = 1'b1;
				hit_slot = slot_idx_t'(i);
			end
		end
	end

	assign ro_hit = addr inside {ADDR_MVENDORID, ADDR_MARCHID, ADDR_MIMPID, ADDR_MHARTID,
		ADDR_MISA, ADDR_MIP};

	// set or clear with a zero operand only reads
	always_comb begin
		case (kind)
			KIND_RW: is_write = 1'b1;
			KIND_RS, KIND_RC: is_write = (operand != '0);
			default: is_write = 1'b0;
		endcase
	end

	assign illegal = (!hit_valid && !ro_hit) || (ro_hit && is_write);

	assign old_val = slots.qout[hit_slot];

	always_comb begin
		case (kind)
			KIND_RS: merged = old_val | operand;
			KIND_RC: merged = old_val & ~operand;
			default: merged = operand;
		endcase
	end

	assign slots.wdata = merged;

	// one-hot enable, read-only hits never reach a slot
	always_comb begin
		for (int i = 0; i < NUM_SLOTS; i++) begin
			slots.wen[i] = req && hit_valid && is_write && (hit_slot == slot_idx_t'(i));
		end
	end

	// trap entry loads four slots, return reloads mstatus only
	always_comb begin
		slots.pen = '0;
		slots.pdata = '{default: '0};
		slots.pen[SLOT_MSTATUS] = trap | xret;
		slots.pen[SLOT_MEPC] = trap;
		slots.pen[SLOT_MCAUSE] = trap;
		slots.pen[SLOT_MTVAL] = trap;
		slots.pdata[SLOT_MSTATUS] = mstatus_trap;
		slots.pdata[SLOT_MEPC] = mepc_trap;
		slots.pdata[SLOT_MCAUSE] = mcause_trap;
		slots.pdata[SLOT_MTVAL] = mtval_trap;
	end

endmodule

//--- rtl/csr_file.sv
`timescale 1ns/1ps

module csr_file import csr_types_pkg::*, csr_map_pkg::*; #(
	parameter int XLEN = 64
) (
	input  logic      CLK,
	input  logic      rst_n,
	input  logic      csr_req,
	input  csr_addr_t csr_addr,
	input  xlen_t     csr_wdata,
	input  logic      csr_rw,
	input  logic      csr_rs,
	input  logic      csr_rc,
	input  logic      trap,
	input  logic      xret,
	input  xlen_t     mstatus_trap,
	input  xlen_t     mepc_trap,
	input  xlen_t     mcause_trap,
	input  xlen_t     mtval_trap,
	input  logic      ext_irq,
	input  logic      timer_irq,
	input  logic      soft_irq,
	output logic      csr_rvalid,
	output xlen_t     csr_rdata,
	output logic      csr_illegal,
	output xlen_t     mstatus_out,
	output xlen_t     mie_out,
	output xlen_t     mip_out,
	output xlen_t     mepc_out,
	output xlen_t     mtvec_out
);

	slot_idx_t hit_slot;
	logic hit_valid;
	logic ro_hit;
	logic illegal;

	csr_slot_if slots ();

	csr_access_ctrl #(.XLEN(XLEN)) u_ctrl (
		.CLK(CLK), .rst_n(rst_n), .req(csr_req), .addr(csr_addr), .wdata(csr_wdata),
		.rw(csr_rw), .rs(csr_rs), .rc(csr_rc), .trap(trap), .xret(xret),
		.mstatus_trap(mstatus_trap), .mepc_trap(mepc_trap), .mcause_trap(mcause_trap),
		.mtval_trap(mtval_trap), .hit_slot(hit_slot), .hit_valid(hit_valid),
		.ro_hit(ro_hit), .illegal(illegal), .slots(slots.ctrl)
	);

	// one writable CSR per table entry
	for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
		csr_slot #(.XLEN(XLEN), .MASK(SLOT_MASK[i])) u_slot (
			.CLK(CLK), .rst_n(rst_n), .wen(slots.wen[i]), .wdata(slots.wdata),
			.pen(slots.pen[i]), .pdata(slots.pdata[i]), .qout(slots.qout[i])
		);
	end

	csr_read_mux #(.XLEN(XLEN)) u_rd (
		.CLK(CLK), .rst_n(rst_n), .req(csr_req), .addr(csr_addr), .hit_slot(hit_slot),
		.hit_valid(hit_valid), .ro_hit(ro_hit), .illegal(illegal), .ext_irq(ext_irq),
		.timer_irq(timer_irq), .soft_irq(soft_irq), .rvalid(csr_rvalid),
		.rdata(csr_rdata), .rd_illegal(csr_illegal), .mip(mip_out), .slots(slots.rd)
	);

	// status view for the privileged logic
	assign mstatus_out = slots.qout[SLOT_MSTATUS] | MSTATUS_FORCED;
	assign mie_out = slots.qout[SLOT_MIE];
	assign mepc_out = slots.qout[SLOT_MEPC];
	assign mtvec_out = slots.qout[SLOT_MTVEC];

endmodule

//--- rtl/csr_map_pkg.sv
package csr_map_pkg;

	import csr_types_pkg::*;

	localparam int NUM_SLOTS = 15;

	// slot numbers the trap path and the status outputs refer to
	localparam slot_idx_t SLOT_MSTATUS = 4'd0;
	localparam slot_idx_t SLOT_MIE     = 4'd3;
	localparam slot_idx_t SLOT_MTVEC   = 4'd4;
	localparam slot_idx_t SLOT_MEPC    = 4'd8;
	localparam slot_idx_t SLOT_MCAUSE  = 4'd9;
	localparam slot_idx_t SLOT_MTVAL   = 4'd10;

	// mstatus medeleg mideleg mie mtvec mcounteren mstatush mscratch
	// mepc mcause mtval mcycle minstret mhpmcounter3 dscratch0
	localparam csr_addr_t SLOT_ADDR [NUM_SLOTS] = '{
		12'h300, 12'h302, 12'h303, 12'h304, 12'h305, 12'h306, 12'h310, 12'h340,
		12'h341, 12'h342, 12'h343, 12'hB00, 12'hB02, 12'hB03, 12'h7B2
	};

	// mtvec keeps bit 1 at zero, mepc stays 4-byte aligned
	localparam xlen_t SLOT_MASK [NUM_SLOTS] = '{
		'1, '1, '1, '1, 64'hFFFF_FFFF_FFFF_FFFD, '1, '1, '1,
		64'hFFFF_FFFF_FFFF_FFFC, '1, '1, '1, '1, '1, '1
	};

	// read-only registers, built outside the slot table
	localparam csr_addr_t ADDR_MVENDORID = 12'hF11;
	localparam csr_addr_t ADDR_MARCHID   = 12'hF12;
	localparam csr_addr_t ADDR_MIMPID    = 12'hF13;
	localparam csr_addr_t ADDR_MHARTID   = 12'hF14;
	localparam csr_addr_t ADDR_MISA      = 12'h301;
	localparam csr_addr_t ADDR_MIP       = 12'h344;

	// MXL = 2 for RV64, extensions A, I, M and U
	localparam xlen_t MISA_VALUE = 64'h8000_0000_0010_1101;

	// MPP reads as machine mode
	localparam xlen_t MSTATUS_FORCED = 64'h0000_0000_0000_1800;

endpackage

//--- rtl/csr_read_mux.sv
`timescale 1ns/1ps

module csr_read_mux import csr_types_pkg::*, csr_map_pkg::*; #(
	parameter int XLEN = 64
) (
	input  logic      CLK,
	input  logic      rst_n,
	input  logic      req,
	input  csr_addr_t addr,
	input  slot_idx_t hit_slot,
	input  logic      hit_valid,
	input  logic      ro_hit,
	input  logic      illegal,
	input  logic      ext_irq,
	input  logic      timer_irq,
	input  logic      soft_irq,
	output logic      rvalid,
	output xlen_t     rdata,
	output logic      rd_illegal,
	output xlen_t     mip,
	csr_slot_if.rd    slots
);

	localparam xlen_t XMASK = xlen_t'({XLEN{1'b1}});

	xlen_t slot_val;
	xlen_t ro_val;
	xlen_t rd_next;

	// MEIP, MTIP and MSIP straight from the interrupt lines
	assign mip = xlen_t'({ext_irq, 3'b000, timer_irq, 3'b000, soft_irq, 3'b000});

	always_comb begin
		slot_val = slots.qout[hit_slot];
		if (hit_slot == SLOT_MSTATUS) begin
			slot_val = slot_val | MSTATUS_FORCED;
		end
	end

	// information registers read as zero
	always_comb begin
		case (addr)
			ADDR_MISA: ro_val = MISA_VALUE;
			ADDR_MIP: ro_val = mip;
			default: ro_val = '0;
		endcase
	end

	always_comb begin
		if (illegal) begin
			rd_next = '0;
		end else if (hit_valid) begin
			rd_next = slot_val & XMASK;
		end else if (ro_hit) begin
			rd_next = ro_val & XMASK;
		end else begin
			rd_next = '0;
		end
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			rvalid <= 1'b0;
			rd_illegal <= 1'b0;
		end else begin
			rvalid <= req;
			rd_illegal <= req & illegal;
		end
	end

	// old value captured at the same edge as the write
	always_ff @(posedge CLK) begin
		if (req) begin
			rdata <= rd_next;
		end
	end

endmodule

//--- rtl/csr_slot.sv
`timescale 1ns/1ps

module csr_slot import csr_types_pkg::*; #(
	parameter int XLEN = 64,
	parameter xlen_t MASK = '1
) (
	input  logic  CLK,
	input  logic  rst_n,
	input  logic  wen,
	input  xlen_t wdata,
	input  logic  pen,
	input  xlen_t pdata,
	output xlen_t qout
);

	logic [XLEN-1:0] q;
	logic [XLEN-1:0] wmask;

	assign wmask = MASK[XLEN-1:0];

	// privileged update has priority over a CSR instruction write
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			q <= '0;
		end else if (pen) begin
			q <= pdata[XLEN-1:0];
		end else if (wen) begin
			// bits outside the mask hold their value
			q <= (q & ~wmask) | (wdata[XLEN-1:0] & wmask);
		end
	end

	// zero extend when built narrower than the data word
	assign qout = xlen_t'(q);

endmodule

//--- rtl/csr_slot_if.sv
`timescale 1ns/1ps

interface csr_slot_if import csr_types_pkg::*, csr_map_pkg::*; ();

	// CSR write path, one enable per slot and one shared word
	logic [NUM_SLOTS-1:0] wen;
	xlen_t wdata;

	// trap entry and return path
	logic [NUM_SLOTS-1:0] pen;
	xlen_t pdata [NUM_SLOTS];

	// current slot contents
	xlen_t qout [NUM_SLOTS];

	modport ctrl (output wen, output wdata, output pen, output pdata, input qout);

	// direction as seen from a single slot
	modport slot (input wen, input wdata, input pen, input pdata, output qout);

	modport rd (input qout);

endinterface

//--- rtl/csr_types_pkg.sv
package csr_types_pkg;

	// widest data word, the design narrows it through XLEN
	typedef logic [63:0] xlen_t;

	// 12-bit CSR address space
	typedef logic [11:0] csr_addr_t;

	// index into the writable slot table
	typedef logic [3:0] slot_idx_t;

	// access kind as {rc, rs, rw}
	typedef logic [2:0] csr_kind_t;

	// read-write, operand replaces the old value
	localparam csr_kind_t KIND_RW = 3'b001;

	// read-set, operand bits are ORed in
	localparam csr_kind_t KIND_RS = 3'b010;

	// read-clear, operand bits are cleared
	localparam csr_kind_t KIND_RC = 3'b100;

endpackage

//--- run.sh
#!/usr/bin/env bash
# builds the CSR file testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module csr_file_tb -o csr_file_sim

./obj_dir/csr_file_sim | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"

//--- src.f
rtl/csr_types_pkg.sv
rtl/csr_map_pkg.sv
rtl/csr_slot_if.sv
rtl/csr_slot.sv
rtl/csr_access_ctrl.sv
rtl/csr_read_mux.sv
rtl/csr_file.sv
verification/csr_file_tb.sv

//--- verification/csr_file_tb.sv
`timescale 1ns/1ps

module csr_file_tb import csr_types_pkg::*; ();

	localparam int MAX_OPS = 64;

	logic clk;
	logic rst_n;
	logic csr_req;
	csr_addr_t csr_addr;
	xlen_t csr_wdata;
	logic csr_rw;
	logic csr_rs;
	logic csr_rc;
	logic trap;
	logic xret;
	xlen_t mstatus_trap;
	xlen_t mepc_trap;
	xlen_t mcause_trap;
	xlen_t mtval_trap;
	logic ext_irq;
	logic timer_irq;
	logic soft_irq;
	logic csr_rvalid;
	xlen_t csr_rdata;
	logic csr_illegal;
	xlen_t mstatus_out;
	xlen_t mie_out;
	xlen_t mip_out;
	xlen_t mepc_out;
	xlen_t mtvec_out;

	// one golden line per entry, fields in file order after the kind letter
	byte op_kind [MAX_OPS];
	xlen_t op_f [MAX_OPS][9];
	int n_ops;
	int errors;
	int op_errors;
	int checks;
	int cycles;
	int cycle_limit;

	csr_file #(.XLEN(64)) dut0 (
		.CLK(clk), .rst_n(rst_n), .csr_req(csr_req), .csr_addr(csr_addr),
		.csr_wdata(csr_wdata), .csr_rw(csr_rw), .csr_rs(csr_rs), .csr_rc(csr_rc),
		.trap(trap), .xret(xret), .mstatus_trap(mstatus_trap), .mepc_trap(mepc_trap),
		.mcause_trap(mcause_trap), .mtval_trap(mtval_trap), .ext_irq(ext_irq),
		.timer_irq(timer_irq), .soft_irq(soft_irq), .csr_rvalid(csr_rvalid),
		.csr_rdata(csr_rdata), .csr_illegal(csr_illegal), .mstatus_out(mstatus_out),
		.mie_out(mie_out), .mip_out(mip_out), .mepc_out(mepc_out), .mtvec_out(mtvec_out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// run limit from the golden file length
	initial begin
		cycles = 0;
		while (cycle_limit == 0 || cycles <= cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run stopped after %0d cycles", cycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

	task automatic count_error();
		errors++;
		op_errors++;
	endtask

	task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
		checks++;
		if (got !== exp) begin
			$display("Error: %s got %h, expected %h", name, got, exp);
			count_error();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("Error: %s got %h, expected %h", name, got, exp);
			count_error();
		end
	endtask

	task automatic check_addr_word(input csr_addr_t addr, input xlen_t got, input xlen_t exp);
		checks++;
		if (got !== exp) begin
			$display("Error: csr_rdata of CSR %h got %h, expected %h", addr, got, exp);
			count_error();
		end
	endtask

	task automatic check_response(input csr_addr_t addr, input xlen_t exp, input logic exp_ill);
		if (csr_rvalid !== 1'b1) begin
			$display("no response one cycle after the request to CSR %h", addr);
			count_error();
		end else begin
			check_addr_word(addr, csr_rdata, exp);
			check_flag("csr_illegal", csr_illegal, exp_ill);
		end
	endtask

	task automatic expect_idle();
		if (csr_rvalid !== 1'b0) begin
			$display("response strobe seen in a cycle that followed no request");
			count_error();
		end
	endtask

	task automatic load_golden();
		int fd;
		string line;
		byte k;
		xlen_t f [9];
		fd = $fopen("verification/csr_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open verification/csr_golden.txt");
			errors++;
			return;
		end
		while (!$feof(fd) && n_ops < MAX_OPS) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line.getc(0) != "#") begin
				f = '{default: '0};
				void'($sscanf(line, "%c %h %h %h %h %h %h %h %h %h", k,
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]));
				op_kind[n_ops] = k;
				op_f[n_ops] = f;
				n_ops++;
			end
		end
		$fclose(fd);
		if (n_ops == 0) begin
			$display("the golden file holds no operations");
			errors++;
		end
	endtask

	task automatic clear_inputs();
		csr_req = 1'b0;
		csr_rw = 1'b0;
		csr_rs = 1'b0;
		csr_rc = 1'b0;
		csr_addr = '0;
		csr_wdata = '0;
		trap = 1'b0;
		xret = 1'b0;
	endtask

	// access lines may ask for no idle cycle before them
	function automatic logic is_chained(input int i);
		return (op_kind[i] inside {"R", "W", "S", "C"}) && op_f[i][4][0];
	endfunction

	task automatic apply_op(input int i);
		clear_inputs();
		case (op_kind[i])
			"T": begin
				trap = 1'b1;
				mstatus_trap = op_f[i][0];
				mepc_trap = op_f[i][1];
				mcause_trap = op_f[i][2];
				mtval_trap = op_f[i][3];
				// same-cycle CSR write that the trap must override
				if (csr_addr_t'(op_f[i][4]) != '0) begin
					csr_req = 1'b1;
					csr_rw = 1'b1;
					csr_addr = csr_addr_t'(op_f[i][4]);
					csr_wdata = op_f[i][5];
				end
			end
			"X": begin
				xret = 1'b1;
				mstatus_trap = op_f[i][0];
			end
			"I": begin
				{ext_irq, timer_irq, soft_irq} = op_f[i][0][2:0];
			end
			default: begin
				csr_req = 1'b1;
				csr_addr = csr_addr_t'(op_f[i][0]);
				csr_wdata = op_f[i][1];
				csr_rw = (op_kind[i] == "W");
				csr_rs = (op_kind[i] == "R") || (op_kind[i] == "S");
				csr_rc = (op_kind[i] == "C");
			end
		endcase
	endtask

	// mie and mtvec outputs hold the old value of a legal access to them
	task automatic check_status_view(input int i);
		if ((op_kind[i] inside {"R", "W", "S", "C"}) && !op_f[i][3][0]) begin
			case (csr_addr_t'(op_f[i][0]))
				12'h304: check_word("mie_out", mie_out, op_f[i][2]);
				12'h305: check_word("mtvec_out", mtvec_out, op_f[i][2]);
				default: ;
			endcase
		end
	endtask

	task automatic check_op(input int i);
		case (op_kind[i])
			"T": begin
				check_word("mstatus_out", mstatus_out, op_f[i][7]);
				check_word("mepc_out", mepc_out, op_f[i][8]);
				if (csr_addr_t'(op_f[i][4]) != '0) begin
					check_response(csr_addr_t'(op_f[i][4]), op_f[i][6], 1'b0);
				end else begin
					expect_idle();
				end
			end
			"X": begin
				check_word("mstatus_out", mstatus_out, op_f[i][1]);
				check_word("mepc_out", mepc_out, op_f[i][2]);
				expect_idle();
			end
			"I": begin
				check_word("mip_out", mip_out, op_f[i][1]);
				expect_idle();
			end
			default: begin
				check_response(csr_addr_t'(op_f[i][0]), op_f[i][2], op_f[i][3][0]);
			end
		endcase
	endtask

	initial begin
		int gap;
		rst_n = 1'b0;
		clear_inputs();
		mstatus_trap = '0;
		mepc_trap = '0;
		mcause_trap = '0;
		mtval_trap = '0;
		ext_irq = 1'b0;
		timer_irq = 1'b0;
		soft_irq = 1'b0;
		n_ops = 0;
		errors = 0;
		checks = 0;
		cycle_limit = 0;
		void'($urandom(55));
		load_golden();
		cycle_limit = n_ops * 4 + 50;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < n_ops; i++) begin
			op_errors = 0;
			if (!is_chained(i)) begin
				clear_inputs();
				gap = $urandom_range(2, 0);
				repeat (gap) begin
					@(negedge clk);
					expect_idle();
				end
			end
			apply_op(i);
			check_status_view(i);
			@(negedge clk);
			check_op(i);
			$display("op %0d (%c): %s", i, op_kind[i], (op_errors == 0) ? "ok" : "failed");
		end
		clear_inputs();
		@(negedge clk);
		$display("tests %0d, checks %0d, errors %0d", n_ops, checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- verification/csr_golden.txt
# R/W/S/C addr operand exp_rdata exp_illegal chain (chain 1: no idle cycle before the request)
# T mstatus mepc mcause mtval waddr wdata exp_rdata exp_mstatus_out exp_mepc_out (waddr 000: no write)
# X mstatus exp_mstatus_out exp_mepc_out
# I irq_lines(ext timer soft) exp_mip_out
R 300 0 1800 0 0
R 302 0 0 0 0
R 303 0 0 0 0
R 304 0 0 0 0
R 305 0 0 0 0
R 306 0 0 0 0
R 310 0 0 0 0
R 340 0 0 0 0
R 341 0 0 0 0
R 342 0 0 0 0
R 343 0 0 0 0
R B00 0 0 0 0
R B02 0 0 0 0
R B03 0 0 0 0
R 7B2 0 0 0 0
W 340 0123456789abcdef 0 0 0
S 340 f000000000000000 0123456789abcdef 0 0
C 340 00000000000000ff f123456789abcdef 0 0
W 305 ffffffffffffffff 0 0 0
S 305 0000000000000002 fffffffffffffffd 0 0
C 305 00000000000000f0 fffffffffffffffd 0 0
W 341 0000000080001237 0 0 0
R 341 0 0000000080001234 0 0
R 301 0 8000000000101101 0 0
R F11 0 0 0 0
R F14 0 0 0 0
I 5 808
R 344 0 808 0 0
R 123 0 0 1 0
W 301 0 0 1 0
R 301 0 8000000000101101 0 0
S 344 800 0 1 0
T 80 80002000 8000000000000007 deadbeef 341 1111 80001234 1880 80002000
R 342 0 8000000000000007 0 0
R 343 0 deadbeef 0 0
X 8 1808 80002000
R 300 0 1808 0 0
W 340 00000000cafef00d f123456789abcd00 0 0
R 340 0 00000000cafef00d 0 1
C 305 ffffffffffffff00 ffffffffffffff0d 0 0
R 305 0 000000000000000d 0 1
